// File: sources.f
ifu_pkg.sv
fetch_ctrl.sv
parcel_buffer.sv
predecode.sv
ifu_top.sv
ifu_properties.sv
tb_ifu.sv

// File: Bender.yml
package:
  name: ifu_frontend

sources:
  - ifu_pkg.sv
  - fetch_ctrl.sv
  - parcel_buffer.sv
  - predecode.sv
  - ifu_top.sv
  - target: test
    files:
      - ifu_properties.sv
      - tb_ifu.sv

// File: tb_ifu.sv
`timescale 1ns/100ps
// testbench for the fetch front end with a memory model, random stall and redirects
// a reference pc walk over the program image scores every new fetch_out
module tb_ifu
  import ifu_pkg::*;
();

  localparam int n_instr        = 1500;
  localparam int timeout_cycles = 4 * n_instr;  // up to 4 cycles per instruction

  logic       clk;
  logic       rst_n;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  redirect_t  pc_update;
  logic       stall;
  fetch_out_t fetch_out;

  logic [15:0] img [512];  // program image, one halfword per entry
  int          seed;
  int          err_count  = 0;
  int          n_checked  = 0;
  int          cycles     = 0;
  int          drv_cycle  = 0;
  logic [30:0] exp_pc     = reset_pc;
  logic        stall_last = 1'b0;

  ifu_top u_ifu_top (.clk, .rst_n, .mem_req, .mem_rsp, .pc_update, .stall, .fetch_out);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ##############################
  // program and reference decode
  // ##############################
  task automatic build_program();
    int          i;
    int          r;
    logic [31:0] w;
    logic [15:0] p;
    logic [4:0]  o;
    i = 0;
    while (i < 512) begin
      r = $random(seed) & 31;
      w = $random(seed);
      p = $random(seed);
      o = 5'd1 + 5'($random(seed) & 15);
      if (i == 511) r = 10;  // no 32-bit word across the image end
      w[17:16] = 2'b00;  // upper halves never decode as 32-bit or jumps
      if (r < 10) begin
        w[6:0] = 7'b0010011;
      end else if (r >= 20 && r < 24) begin
        w[6:0] = 7'b1100011;
      end else if (r == 26) begin
        w = {1'b0, 5'd0, o + 5'd1, 1'b0, 8'h00, w[11:7], 7'b1101111};  // jal forward
      end else if (r == 24 || r == 25) begin
        p[15:14] = 2'b11;
        p[1:0]   = 2'b01;
      end else if (r == 27) begin
        p = {3'b101, 1'b0, o[3], 5'b00000, o[2:0], o[4], 2'b01};  // c.j forward
      end else if (r == 28) begin
        p = ($random(seed) & 1) ? 16'hffff : 16'h0000;
      end else begin
        p[1:0] = 2'b10;
      end
      if (r < 10 || (r >= 20 && r < 24) || r == 26) begin
        img[i]   = w[15:0];
        img[i+1] = w[31:16];
        i += 2;
      end else begin
        img[i] = p;
        i += 1;
        if (p == 16'hffff) begin
          img[i] = {w[15:2], 2'b00};
          i += 1;
        end
      end
    end
  endtask

  function automatic logic [31:0] word_at(input logic [30:0] pc);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = img[pc[8:0]];
    hi = img[9'(pc[8:0] + 9'd1)];
    if (lo[1:0] == 2'b11) return {hi, lo};
    return {16'h0000, lo};
  endfunction

  function automatic logic is_branch(input logic [31:0] w);
    if (w[1:0] == 2'b11) return w[6:0] == 7'b1100011;
    return w[1:0] == 2'b01 && w[15:14] == 2'b11;  // c.beqz, c.bnez
  endfunction

  function automatic logic is_jump(input logic [31:0] w);
    if (w[1:0] == 2'b11) return w[6:0] == 7'b1101111;
    return w[1:0] == 2'b01 && w[14:13] == 2'b01;  // c.j, c.jal
  endfunction

  function automatic logic [30:0] jump_offset(input logic [31:0] w);
    logic signed [20:0] imm;
    logic signed [11:0] cimm;
    logic signed [30:0] off;
    imm  = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    cimm = {w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    if (w[1:0] == 2'b11) off = imm;
    else off = cimm;
    return off >>> 1;  // bytes to halfwords
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (exp === act) else begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic score_output();
    logic [31:0] w;
    w = word_at(exp_pc);
    compare_value("fetch.pc", 32'(exp_pc), 32'(fetch_out.pc));
    compare_value("fetch.instr", w, fetch_out.instr);
    compare_value("fetch.compressed", 32'(w[1:0] != 2'b11), 32'(fetch_out.compressed));
    compare_value("predecode.br", 32'(is_branch(w)), 32'(fetch_out.br));
    compare_value("predecode.jump", 32'(is_jump(w)), 32'(fetch_out.jump));
    compare_value("predecode.illegal", 32'(w[15:0] == 16'h0000 || w[15:0] == 16'hffff),
                  32'(fetch_out.illegal));
    n_checked++;
    if (is_jump(w)) exp_pc = exp_pc + jump_offset(w);
    else exp_pc = exp_pc + ((w[1:0] == 2'b11) ? 31'd2 : 31'd1);
  endtask

  // held outputs during stall are not new
  always @(negedge clk) begin
    if (rst_n) begin
      if (fetch_out.valid && !stall_last) score_output();
      if (pc_update.valid) exp_pc = pc_update.pc;  // walk restarts here
    end
    stall_last = stall;
  end

  // ##############################
  // memory model
  // ##############################
  initial begin
    int         delay;
    logic [8:0] h;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req.req) begin
        h     = mem_req.addr[9:1];
        delay = 1 + ($random(seed) & 3);
        repeat (delay) @(posedge clk);
        #1;
        mem_rsp.valid = 1'b1;
        mem_rsp.data  = {img[h+3], img[h+2], img[h+1], img[h]};
        @(posedge clk);
        #1 mem_rsp.valid = 1'b0;
      end
    end
  end

  initial begin
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, only %0d instructions seen in %0d cycles", n_checked, cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed      = 33364;
    rst_n     = 1'b1;
    stall     = 1'b0;
    pc_update = '0;
    mem_rsp   = '0;
    build_program();
    #1 rst_n = 1'b0;  // clean falling edge
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    while (n_checked < n_instr) begin
      @(posedge clk);
      #1;
      drv_cycle++;
      stall     = (($random(seed) & 7) == 0);
      pc_update = '0;
      if (drv_cycle % 280 == 140) begin
        pc_update.valid = 1'b1;
        pc_update.pc    = {22'd0, 8'($random(seed)), 1'b0};
      end
    end
    @(posedge clk);
    #1 stall = 1'b0;
    pc_update = '0;
    @(negedge clk);
    $display("instructions checked %0d, scoreboard errors %0d, property errors %0d",
             n_checked, err_count, u_ifu_top.u_ifu_properties.prop_errors);
    if (err_count == 0 && u_ifu_top.u_ifu_properties.prop_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: ifu_properties.sv
`timescale 1ns/100ps
// protocol checks for the fetch front end, bound into every ifu_top
module ifu_properties
  import ifu_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input mem_req_t   mem_req,
  input mem_rsp_t   mem_rsp,
  input logic       stall,
  input fetch_out_t fetch_out
);

  int   prop_errors = 0;
  logic outstanding;  // read issued, answer not yet back

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (mem_req.req) begin
      outstanding <= 1'b1;
    end else if (mem_rsp.valid) begin
      outstanding <= 1'b0;
    end
  end

  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> fetch_out === $past(fetch_out))
    else begin $error("fetch_out changed while stalled"); prop_errors++; end

  single_read: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding |-> !mem_req.req)
    else begin $error("second strobe before the response"); prop_errors++; end

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !mem_req.req && !fetch_out.valid)
    else begin $error("strobe or fetch_out valid during reset"); prop_errors++; end

  // boot line is requested right after reset
  boot_fetch: assert property (@(posedge clk) $rose(rst_n) |-> mem_req.req)
    else begin $error("no strobe in the first cycle after reset"); prop_errors++; end

endmodule

bind ifu_top ifu_properties u_ifu_properties (.*);

// File: ifu_top.sv
`timescale 1ns/100ps
// instruction fetch front end, fetch controller -> parcel buffer -> predecoder
module ifu_top
  import ifu_pkg::*;
#(
  parameter int          depth   = buf_depth,
  parameter logic [30:0] boot_pc = reset_pc
) (
  input  logic       clk,
  input  logic       rst_n,
  output mem_req_t   mem_req,
  input  mem_rsp_t   mem_rsp,
  input  redirect_t  pc_update,
  input  logic       stall,
  output fetch_out_t fetch_out
);

  redirect_t              redirect;  // merged, flushes and restarts fetch
  logic                   wr_line;
  logic [line_bits-1:0]   wr_data;
  logic [1:0]             wr_skip;
  logic                   space;
  logic                   inflight;
  logic [parcel_bits-1:0] parcel0;
  logic [parcel_bits-1:0] parcel1;
  logic [$clog2(depth):0] count;
  logic [1:0]             pop;

  fetch_ctrl #(.boot_pc(boot_pc)) u_fetch_ctrl (
    .clk, .rst_n, .space, .redirect, .mem_req, .mem_rsp,
    .wr_line, .wr_data, .wr_skip, .inflight
  );

  parcel_buffer #(.depth(depth)) u_parcel_buffer (
    .clk, .rst_n, .flush(redirect.valid), .wr_line, .wr_data, .wr_skip,
    .pop, .parcel0, .parcel1, .count, .space, .inflight
  );

  predecode #(
    .boot_pc(boot_pc),
    .depth  (depth)
  ) u_predecode (
    .clk, .rst_n, .parcel0, .parcel1, .count, .stall, .pc_update,
    .pop, .redirect, .fetch_out
  );

endmodule

// File: predecode.sv
`timescale 1ns/100ps
// predecoder, takes one instruction per cycle from the parcel queue
// classifies it, redirects on direct jumps and registers the result
module predecode
  import ifu_pkg::*;
#(
  parameter logic [30:0] boot_pc = reset_pc,
  parameter int          depth   = buf_depth
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [parcel_bits-1:0] parcel0,
  input  logic [parcel_bits-1:0] parcel1,
  input  logic [$clog2(depth):0] count,
  input  logic                   stall,
  input  redirect_t              pc_update,
  output logic [1:0]             pop,
  output redirect_t              redirect,
  output fetch_out_t             fetch_out
);

  logic        is32;
  logic        avail;
  logic        fire;
  logic        jump;
  logic [31:0] instr;
  instr_kind_e kind;
  logic [30:0] pc_q;
  logic [30:0] jump_off;  // halfwords, sign extended
  logic [30:0] target;
  fetch_out_t  out_q;

  assign is32  = (parcel0[1:0] == 2'b11);
  assign avail = is32 ? (count >= 2) : (count >= 1);
  assign fire  = avail && !stall;
  assign pop   = fire ? (is32 ? 2'd2 : 2'd1) : 2'd0;
  assign instr = is32 ? {parcel1, parcel0} : {16'h0000, parcel0};

  // ############################
  // classify
  // ############################
  always_comb begin
    kind     = kind_plain;
    jump_off = '0;
    if (parcel0 == '0 || parcel0 == '1) begin
      kind = kind_illegal;
    end else if (is32) begin
      case (instr[6:0])
        7'b1100011: kind = kind_branch;
        7'b1101111: begin  // jal
          kind     = kind_jal;
          jump_off = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21]};
        end
        default: ;
      endcase
    end else if (parcel0[1:0] == 2'b01) begin
      case (parcel0[15:13])
        3'b110, 3'b111: kind = kind_branch;  // c.beqz, c.bnez
        3'b001, 3'b101: begin
          kind     = kind_cj;
          jump_off = {{20{parcel0[12]}}, parcel0[12], parcel0[8], parcel0[10:9],
                      parcel0[6], parcel0[7], parcel0[2], parcel0[11], parcel0[5:3]};
        end
        default: ;
      endcase
    end
  end

  assign jump   = (kind == kind_jal) || (kind == kind_cj);
  assign target = pc_q + jump_off;

  // back end update beats our own jump
  always_comb begin
    redirect = pc_update;
    if (!pc_update.valid) begin
      redirect.valid = fire && jump;
      redirect.pc    = target;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= boot_pc;
    end else if (redirect.valid) begin
      pc_q <= redirect.pc;
    end else if (fire) begin
      pc_q <= pc_q + (is32 ? 31'd2 : 31'd1);
    end
  end

  // ############################
  // output stage
  // ############################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_q <= '0;
    end else if (!stall) begin  // held while stalled
      out_q.valid      <= fire && !pc_update.valid;
      out_q.instr      <= instr;
      out_q.pc         <= pc_q;
      out_q.compressed <= !is32;
      out_q.br         <= (kind == kind_branch);
      out_q.jump       <= jump;
      out_q.illegal    <= (kind == kind_illegal);
    end
  end

  assign fetch_out = out_q;

endmodule

// File: parcel_buffer.sv
`timescale 1ns/100ps
// circular queue of 16-bit parcels between the fetch controller and the predecoder
// lines come in four parcels at a time minus the skip, the predecoder pops 0..2 per cycle
module parcel_buffer
  import ifu_pkg::*;
#(
  parameter int depth = buf_depth
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   wr_line,
  input  logic [line_bits-1:0]   wr_data,
  input  logic [1:0]             wr_skip,
  input  logic [1:0]             pop,
  output logic [parcel_bits-1:0] parcel0,
  output logic [parcel_bits-1:0] parcel1,
  output logic [$clog2(depth):0] count,
  output logic                   space,
  input  logic                   inflight
);

  localparam int aw = $clog2(depth);

  logic [parcel_bits-1:0] mem [depth];
  logic [aw-1:0]          rd_ptr;
  logic [aw-1:0]          wr_ptr;
  logic [2:0]             n_wr;

  // depth need not be a power of two
  function automatic logic [aw-1:0] wrap(input int unsigned idx);
    if (idx >= depth) begin
      return aw'(idx - depth);
    end
    return aw'(idx);
  endfunction

  assign n_wr = wr_line ? 3'(3'd4 - {1'b0, wr_skip}) : 3'd0;

  // ############################
  // storage
  // ############################
  always_ff @(posedge clk) begin
    if (wr_line) begin
      for (int i = 0; i < parcels_per_line; i++) begin
        if (i >= wr_skip) begin
          mem[wrap(32'(wr_ptr) + i - wr_skip)] <= wr_data[i*parcel_bits +: parcel_bits];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin  // wins over write and pop
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= wrap(32'(rd_ptr) + 32'(pop));
      wr_ptr <= wrap(32'(wr_ptr) + 32'(n_wr));
      count  <= count + n_wr - pop;
    end
  end

  assign parcel0 = mem[rd_ptr];
  assign parcel1 = mem[wrap(32'(rd_ptr) + 32'd1)];

  // room for a whole line, counting the one still coming back
  assign space = (int'(count) + (inflight ? 4 : 0)) <= (depth - parcels_per_line);

endmodule

// File: fetch_ctrl.sv
`timescale 1ns/100ps
// fetch controller, keeps the next line address and issues one line read at a time
// answers to reads issued before a redirect are dropped before they reach the buffer
module fetch_ctrl
  import ifu_pkg::*;
#(
  parameter logic [30:0] boot_pc = reset_pc
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 space,
  input  redirect_t            redirect,
  output mem_req_t             mem_req,
  input  mem_rsp_t             mem_rsp,
  output logic                 wr_line,
  output logic [line_bits-1:0] wr_data,
  output logic [1:0]           wr_skip,
  output logic                 inflight
);

  fetch_state_e state_q, state_d;
  logic [28:0]  line_q, line_d;  // next line index, byte addr [31:3]
  logic [1:0]   skip_pend_q, skip_pend_d;
  logic [1:0]   skip_cur_q, skip_cur_d;  // skip of the read in flight
  logic         issue;
  logic [28:0]  req_line;
  logic [1:0]   req_skip;

  // a redirect in idle goes straight out as the request
  assign req_line = redirect.valid ? redirect.pc[30:2] : line_q;
  assign req_skip = redirect.valid ? redirect.pc[1:0] : skip_pend_q;
  assign issue    = rst_n && (state_q == st_idle) && (redirect.valid || space);  // quiet in reset

  assign mem_req.req  = issue;
  assign mem_req.addr = {req_line, 3'b000};

  assign wr_line  = (state_q == st_wait) && mem_rsp.valid && !redirect.valid;
  assign wr_data  = mem_rsp.data;
  assign wr_skip  = skip_cur_q;
  assign inflight = (state_q == st_wait);

  // ############################
  // fsm
  // ############################
  always_comb begin
    state_d     = state_q;
    line_d      = line_q;
    skip_pend_d = skip_pend_q;
    skip_cur_d  = skip_cur_q;
    case (state_q)
      st_idle: begin
        if (issue) begin
          line_d      = req_line + 29'd1;
          skip_cur_d  = req_skip;
          skip_pend_d = 2'd0;  // only the first line after a redirect skips
          state_d     = st_wait;
        end
      end
      st_wait, st_drop: begin
        if (redirect.valid) begin
          line_d      = redirect.pc[30:2];
          skip_pend_d = redirect.pc[1:0];
          state_d     = mem_rsp.valid ? st_idle : st_drop;
        end else if (mem_rsp.valid) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= st_idle;
      line_q      <= boot_pc[30:2];
      skip_pend_q <= boot_pc[1:0];
      skip_cur_q  <= 2'd0;
    end else begin
      state_q     <= state_d;
      line_q      <= line_d;
      skip_pend_q <= skip_pend_d;
      skip_cur_q  <= skip_cur_d;
    end
  end

endmodule

// File: ifu_pkg.sv
// shared types and constants for the instruction fetch front end
// modules pull these in with a wildcard import in their header
package ifu_pkg;

  // ############################
  // sizes
  // ############################
  localparam int line_bits        = 64;
  localparam int parcel_bits      = 16;
  localparam int parcels_per_line = 4;
  localparam int buf_depth        = 8;  // parcels, 8/12/16 supported

  // boot address as a halfword pc
  localparam logic [30:0] reset_pc = 31'h0000_0000;

  // ############################
  // enums
  // ############################
  typedef enum logic [2:0] {
    kind_plain,
    kind_branch,   // beq.. and c.beqz/c.bnez
    kind_jal,
    kind_cj,       // c.j, c.jal
    kind_illegal
  } instr_kind_e;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,       // read outstanding, answer is used
    st_drop        // read outstanding, answer is stale
  } fetch_state_e;

  // ############################
  // bundles
  // ############################
  typedef struct packed {
    logic        req;   // one-cycle strobe
    logic [31:0] addr;  // byte address, 8-byte aligned
  } mem_req_t;

  typedef struct packed {
    logic                 valid;
    logic [line_bits-1:0] data;  // parcel 0 in the low bits
  } mem_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [30:0] pc;  // halfword address
  } redirect_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;  // 16-bit forms zero extended
    logic [30:0] pc;
    logic        compressed;
    logic        br;
    logic        jump;
    logic        illegal;
  } fetch_out_t;

endpackage
